//--- exu_geom_pkg.sv
`default_nettype none

package exu_geom_pkg;

   // data path and address width
   localparam int xlen = 32;

   // architectural register count with register 0 reading as zero
   localparam int num_regs = 32;

   // pc step to the next instruction and the link offset
   localparam int inst_bytes = 4;

   typedef logic [xlen-1:0] xword_t;

   typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- exu_op_pkg.sv
`default_nettype none

package exu_op_pkg;

   // alu operations where lui passes operand b through
   typedef enum logic [3:0] {
      alu_add  = 4'h0,
      alu_sub  = 4'h1,
      alu_slt  = 4'h2,
      alu_sltu = 4'h3,
      alu_and  = 4'h4,
      alu_or   = 4'h5,
      alu_xor  = 4'h6,
      alu_sll  = 4'h7,
      alu_srl  = 4'h8,
      alu_sra  = 4'h9,
      alu_lui  = 4'ha
   } alu_op_t;

   // compare branches first, then the unconditional kinds
   typedef enum logic [3:0] {
      bru_beq  = 4'h0,
      bru_bne  = 4'h1,
      bru_blt  = 4'h2,
      bru_bge  = 4'h3,
      bru_bltu = 4'h4,
      bru_bgeu = 4'h5,
      bru_b    = 4'h6,
      bru_bl   = 4'h7,
      bru_jirl = 4'h8
   } bru_op_t;

endpackage

`default_nettype wire

//--- exu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module exu_regfile import exu_geom_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   input  reg_idx_t raddr1,
   input  reg_idx_t raddr2,
   output xword_t   rdata1,
   output xword_t   rdata2,

   input  logic     wen,
   input  reg_idx_t waddr,
   input  xword_t   wdata
);

   // register 0 has no storage
   xword_t regs [1:num_regs-1];

   // architectural state starts cleared
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // write-through so a W write is seen by the D read of the same cycle
   always_comb begin
      rdata1 = '0;
      rdata2 = '0;
      if (raddr1 != '0) begin
         rdata1 = (wen && waddr == raddr1) ? wdata : regs[raddr1];
      end
      if (raddr2 != '0) begin
         rdata2 = (wen && waddr == raddr2) ? wdata : regs[raddr2];
      end
   end

endmodule

`default_nettype wire

//--- exu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module exu_issue import exu_geom_pkg::*, exu_op_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   // decoded instruction at D
   input  logic     vld_d,
   input  xword_t   pc_d,
   input  reg_idx_t rs1_d,
   input  reg_idx_t rs2_d,
   input  reg_idx_t rd_d,
   input  logic     wen_d,
   input  xword_t   imm_d,
   input  logic     alu_vld_d,
   input  alu_op_t  alu_op_d,
   input  logic     alu_a_pc_d,
   input  logic     alu_b_imm_d,
   input  logic     bru_vld_d,
   input  bru_op_t  bru_op_d,
   input  xword_t   bru_offset_d,

   input  xword_t   rf_rdata1,
   input  xword_t   rf_rdata2,

   input  logic     flush,

   // bypass sources
   input  logic     wen_m,
   input  reg_idx_t rd_m,
   input  xword_t   rd_data_m,
   input  logic     wen_w,
   input  reg_idx_t rd_w,
   input  xword_t   rd_data_w,

   // E stage
   output xword_t   pc_e,
   output reg_idx_t rd_e,
   output logic     wen_e,
   output xword_t   imm_e,
   output logic     alu_vld_e,
   output alu_op_t  alu_op_e,
   output logic     alu_a_pc_e,
   output logic     alu_b_imm_e,
   output logic     bru_vld_e,
   output bru_op_t  bru_op_e,
   output xword_t   bru_offset_e,
   output xword_t   rs1_val_e,
   output xword_t   rs2_val_e
);

   logic     issue;
   reg_idx_t rs1_e;
   reg_idx_t rs2_e;
   xword_t   rf_data1_e;
   xword_t   rf_data2_e;

   // M is younger than W, so it wins
   function automatic xword_t fwd_sel(
      input reg_idx_t rs,
      input xword_t   rf_val,
      input logic     m_wen,
      input reg_idx_t m_rd,
      input xword_t   m_data,
      input logic     w_wen,
      input reg_idx_t w_rd,
      input xword_t   w_data
   );
      xword_t val;
      val = rf_val;
      if (w_wen && w_rd != '0 && w_rd == rs) begin
         val = w_data;
      end
      if (m_wen && m_rd != '0 && m_rd == rs) begin
         val = m_data;
      end
      return val;
   endfunction

   // slots behind a taken branch are dropped here
   assign issue = vld_d & ~flush;

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_e     <= 1'b0;
         alu_vld_e <= 1'b0;
         bru_vld_e <= 1'b0;
      end else begin
         wen_e     <= wen_d & issue;
         alu_vld_e <= alu_vld_d & issue;
         bru_vld_e <= bru_vld_d & issue;
      end
   end

   always_ff @(posedge clk) begin
      pc_e         <= pc_d;
      rs1_e        <= rs1_d;
      rs2_e        <= rs2_d;
      rd_e         <= rd_d;
      imm_e        <= imm_d;
      alu_op_e     <= alu_op_d;
      alu_a_pc_e   <= alu_a_pc_d;
      alu_b_imm_e  <= alu_b_imm_d;
      bru_op_e     <= bru_op_d;
      bru_offset_e <= bru_offset_d;
      rf_data1_e   <= rf_rdata1;
      rf_data2_e   <= rf_rdata2;
   end

   assign rs1_val_e = fwd_sel(rs1_e, rf_data1_e, wen_m, rd_m, rd_data_m,
                              wen_w, rd_w, rd_data_w);
   assign rs2_val_e = fwd_sel(rs2_e, rf_data2_e, wen_m, rd_m, rd_data_m,
                              wen_w, rd_w, rd_data_w);

endmodule

`default_nettype wire

//--- exu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module exu_execute import exu_geom_pkg::*, exu_op_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   // E stage
   input  xword_t   pc_e,
   input  reg_idx_t rd_e,
   input  logic     wen_e,
   input  xword_t   imm_e,
   input  logic     alu_vld_e,
   input  alu_op_t  alu_op_e,
   input  logic     alu_a_pc_e,
   input  logic     alu_b_imm_e,
   input  logic     bru_vld_e,
   input  bru_op_t  bru_op_e,
   input  xword_t   bru_offset_e,
   input  xword_t   rs1_val_e,
   input  xword_t   rs2_val_e,

   output logic     taken_e,

   // M stage
   output logic     alu_vld_m,
   output logic     bru_vld_m,
   output logic     wen_m,
   output reg_idx_t rd_m,
   output xword_t   alu_res_m,
   output xword_t   link_m,
   output logic     taken_m,
   output xword_t   target_m
);

   xword_t     alu_a;
   xword_t     alu_b;
   xword_t     alu_res_e;
   xword_t     link_e;
   xword_t     target_e;
   logic [4:0] shamt;
   logic       eq;
   logic       lt;
   logic       ltu;
   logic       cond;

   assign alu_a = alu_a_pc_e ? pc_e : rs1_val_e;
   assign alu_b = alu_b_imm_e ? imm_e : rs2_val_e;
   assign shamt = alu_b[4:0];

   always_comb begin
      case (alu_op_e)
         alu_add:  alu_res_e = alu_a + alu_b;
         alu_sub:  alu_res_e = alu_a - alu_b;
         alu_slt:  alu_res_e = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
         alu_sltu: alu_res_e = {{(xlen-1){1'b0}}, alu_a < alu_b};
         alu_and:  alu_res_e = alu_a & alu_b;
         alu_or:   alu_res_e = alu_a | alu_b;
         alu_xor:  alu_res_e = alu_a ^ alu_b;
         alu_sll:  alu_res_e = alu_a << shamt;
         alu_srl:  alu_res_e = alu_a >> shamt;
         alu_sra:  alu_res_e = xword_t'($signed(alu_a) >>> shamt);
         alu_lui:  alu_res_e = alu_b;
         default:  alu_res_e = '0;
      endcase
   end

   // branch compares always use the register operands
   assign eq  = rs1_val_e == rs2_val_e;
   assign lt  = $signed(rs1_val_e) < $signed(rs2_val_e);
   assign ltu = rs1_val_e < rs2_val_e;

   always_comb begin
      case (bru_op_e)
         bru_beq:  cond = eq;
         bru_bne:  cond = ~eq;
         bru_blt:  cond = lt;
         bru_bge:  cond = ~lt;
         bru_bltu: cond = ltu;
         bru_bgeu: cond = ~ltu;
         bru_b, bru_bl, bru_jirl: cond = 1'b1;
         default:  cond = 1'b0;
      endcase
   end

   assign taken_e  = bru_vld_e & cond;
   assign target_e = ((bru_op_e == bru_jirl) ? rs1_val_e : pc_e) + bru_offset_e;
   assign link_e   = pc_e + xword_t'(inst_bytes);

   always_ff @(posedge clk) begin
      if (reset) begin
         alu_vld_m <= 1'b0;
         bru_vld_m <= 1'b0;
         wen_m     <= 1'b0;
         rd_m      <= '0;
         taken_m   <= 1'b0;
      end else begin
         alu_vld_m <= alu_vld_e;
         bru_vld_m <= bru_vld_e;
         wen_m     <= wen_e;
         rd_m      <= rd_e;
         taken_m   <= taken_e;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_m <= alu_res_e;
      link_m    <= link_e;
      target_m  <= target_e;
   end

endmodule

`default_nettype wire

//--- exu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module exu_writeback import exu_geom_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   // M stage
   input  logic     alu_vld_m,
   input  logic     bru_vld_m,
   input  logic     wen_m,
   input  reg_idx_t rd_m,
   input  xword_t   alu_res_m,
   input  xword_t   link_m,
   input  logic     taken_m,
   input  xword_t   target_m,

   output xword_t   rd_data_m,

   // retire port and register file write
   output logic     wen_w,
   output reg_idx_t rd_w,
   output xword_t   rd_data_w,

   // redirect to fetch
   output logic     branch_w,
   output xword_t   brn_addr_w
);

   // result of whichever unit holds the instruction in M
   assign rd_data_m = ({xlen{alu_vld_m}} & alu_res_m) |
                      ({xlen{bru_vld_m}} & link_m);

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_w    <= 1'b0;
         rd_w     <= '0;
         branch_w <= 1'b0;
      end else begin
         wen_w    <= wen_m;
         rd_w     <= rd_m;
         branch_w <= taken_m;
      end
   end

   always_ff @(posedge clk) begin
      rd_data_w  <= rd_data_m;
      brn_addr_w <= target_m;
   end

endmodule

`default_nettype wire

//--- exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_geom_pkg::*, exu_op_pkg::*; (
   input  logic     clk,
   input  logic     reset,

   // decoded instruction at D
   input  logic     vld_d,
   input  xword_t   pc_d,
   input  reg_idx_t rs1_d,
   input  reg_idx_t rs2_d,
   input  reg_idx_t rd_d,
   input  logic     wen_d,
   input  xword_t   imm_d,
   input  logic     alu_vld_d,
   input  alu_op_t  alu_op_d,
   input  logic     alu_a_pc_d,
   input  logic     alu_b_imm_d,
   input  logic     bru_vld_d,
   input  bru_op_t  bru_op_d,
   input  xword_t   bru_offset_d,

   // retire
   output logic     wen_w,
   output reg_idx_t rd_w,
   output xword_t   rd_data_w,

   // redirect
   output logic     branch_w,
   output xword_t   brn_addr_w
);

   xword_t   rf_rdata1;
   xword_t   rf_rdata2;
   logic     flush;

   xword_t   pc_e;
   reg_idx_t rd_e;
   logic     wen_e;
   xword_t   imm_e;
   logic     alu_vld_e;
   alu_op_t  alu_op_e;
   logic     alu_a_pc_e;
   logic     alu_b_imm_e;
   logic     bru_vld_e;
   bru_op_t  bru_op_e;
   xword_t   bru_offset_e;
   xword_t   rs1_val_e;
   xword_t   rs2_val_e;
   logic     taken_e;

   logic     alu_vld_m;
   logic     bru_vld_m;
   logic     wen_m;
   reg_idx_t rd_m;
   xword_t   alu_res_m;
   xword_t   link_m;
   logic     taken_m;
   xword_t   target_m;
   xword_t   rd_data_m;

   // a taken branch kills D while it sits in E, M or W
   assign flush = taken_e | taken_m | branch_w;

   exu_regfile u_rf (
      .clk    (clk),
      .reset  (reset),
      .raddr1 (rs1_d),
      .raddr2 (rs2_d),
      .rdata1 (rf_rdata1),
      .rdata2 (rf_rdata2),
      .wen    (wen_w),
      .waddr  (rd_w),
      .wdata  (rd_data_w)
   );

   exu_issue u_issue (
      .clk          (clk),
      .reset        (reset),
      .vld_d        (vld_d),
      .pc_d         (pc_d),
      .rs1_d        (rs1_d),
      .rs2_d        (rs2_d),
      .rd_d         (rd_d),
      .wen_d        (wen_d),
      .imm_d        (imm_d),
      .alu_vld_d    (alu_vld_d),
      .alu_op_d     (alu_op_d),
      .alu_a_pc_d   (alu_a_pc_d),
      .alu_b_imm_d  (alu_b_imm_d),
      .bru_vld_d    (bru_vld_d),
      .bru_op_d     (bru_op_d),
      .bru_offset_d (bru_offset_d),
      .rf_rdata1    (rf_rdata1),
      .rf_rdata2    (rf_rdata2),
      .flush        (flush),
      .wen_m        (wen_m),
      .rd_m         (rd_m),
      .rd_data_m    (rd_data_m),
      .wen_w        (wen_w),
      .rd_w         (rd_w),
      .rd_data_w    (rd_data_w),
      .pc_e         (pc_e),
      .rd_e         (rd_e),
      .wen_e        (wen_e),
      .imm_e        (imm_e),
      .alu_vld_e    (alu_vld_e),
      .alu_op_e     (alu_op_e),
      .alu_a_pc_e   (alu_a_pc_e),
      .alu_b_imm_e  (alu_b_imm_e),
      .bru_vld_e    (bru_vld_e),
      .bru_op_e     (bru_op_e),
      .bru_offset_e (bru_offset_e),
      .rs1_val_e    (rs1_val_e),
      .rs2_val_e    (rs2_val_e)
   );

   exu_execute u_execute (
      .clk          (clk),
      .reset        (reset),
      .pc_e         (pc_e),
      .rd_e         (rd_e),
      .wen_e        (wen_e),
      .imm_e        (imm_e),
      .alu_vld_e    (alu_vld_e),
      .alu_op_e     (alu_op_e),
      .alu_a_pc_e   (alu_a_pc_e),
      .alu_b_imm_e  (alu_b_imm_e),
      .bru_vld_e    (bru_vld_e),
      .bru_op_e     (bru_op_e),
      .bru_offset_e (bru_offset_e),
      .rs1_val_e    (rs1_val_e),
      .rs2_val_e    (rs2_val_e),
      .taken_e      (taken_e),
      .alu_vld_m    (alu_vld_m),
      .bru_vld_m    (bru_vld_m),
      .wen_m        (wen_m),
      .rd_m         (rd_m),
      .alu_res_m    (alu_res_m),
      .link_m       (link_m),
      .taken_m      (taken_m),
      .target_m     (target_m)
   );

   exu_writeback u_writeback (
      .clk        (clk),
      .reset      (reset),
      .alu_vld_m  (alu_vld_m),
      .bru_vld_m  (bru_vld_m),
      .wen_m      (wen_m),
      .rd_m       (rd_m),
      .alu_res_m  (alu_res_m),
      .link_m     (link_m),
      .taken_m    (taken_m),
      .target_m   (target_m),
      .rd_data_m  (rd_data_m),
      .wen_w      (wen_w),
      .rd_w       (rd_w),
      .rd_data_w  (rd_data_w),
      .branch_w   (branch_w),
      .brn_addr_w (brn_addr_w)
   );

endmodule

`default_nettype wire

//--- tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu import exu_geom_pkg::*, exu_op_pkg::*;;

   localparam int n_idle = 10;
   localparam int n_alu = 40;
   localparam int n_dep = 24;
   localparam int n_r0 = 4;
   localparam int n_br = 40;
   localparam int n_mix = 200;
   localparam int drain = 4;
   localparam int limit = 2 + n_idle + n_alu * 4 + 3 * n_dep + n_r0 * 4 + n_br * 4
                          + n_mix + 6 * drain + 20;

   logic     clk;
   logic     reset;
   logic     vld_d;
   xword_t   pc_d;
   reg_idx_t rs1_d;
   reg_idx_t rs2_d;
   reg_idx_t rd_d;
   logic     wen_d;
   xword_t   imm_d;
   logic     alu_vld_d;
   alu_op_t  alu_op_d;
   logic     alu_a_pc_d;
   logic     alu_b_imm_d;
   logic     bru_vld_d;
   bru_op_t  bru_op_d;
   xword_t   bru_offset_d;
   logic     wen_w;
   reg_idx_t rd_w;
   xword_t   rd_data_w;
   logic     branch_w;
   xword_t   brn_addr_w;

   // reference state and the three-slot expectation pipe
   xword_t   regs [0:num_regs-1];
   xword_t   pc;
   int       skip;
   logic     p_wen [3];
   reg_idx_t p_rd [3];
   xword_t   p_data [3];
   logic     p_br [3];
   xword_t   p_addr [3];
   reg_idx_t hist [3];
   int       cycles;
   int       test_no;
   int       n_checks;
   int       n_retire;
   int       test_errs;
   int       total_errs;

   exu_top dut_i (
      .clk (clk), .reset (reset), .vld_d (vld_d), .pc_d (pc_d),
      .rs1_d (rs1_d), .rs2_d (rs2_d), .rd_d (rd_d), .wen_d (wen_d),
      .imm_d (imm_d), .alu_vld_d (alu_vld_d), .alu_op_d (alu_op_d),
      .alu_a_pc_d (alu_a_pc_d), .alu_b_imm_d (alu_b_imm_d),
      .bru_vld_d (bru_vld_d), .bru_op_d (bru_op_d), .bru_offset_d (bru_offset_d),
      .wen_w (wen_w), .rd_w (rd_w), .rd_data_w (rd_data_w),
      .branch_w (branch_w), .brn_addr_w (brn_addr_w)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= limit) begin
         $display("timeout: run did not end within %0d cycles", limit);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic xword_t alu_model(input alu_op_t op, input xword_t a, input xword_t b);
      logic [2*xlen-1:0] ext;
      ext = {{xlen{a[xlen-1]}}, a} >> b[4:0];
      case (op)
         alu_add:  return a + b;
         alu_sub:  return a + ~b + 32'd1;
         // signs differ, so the negative one is smaller
         alu_slt:  return (a[xlen-1] != b[xlen-1]) ? xword_t'(a[xlen-1]) : xword_t'(a < b);
         alu_sltu: return xword_t'(a < b);
         alu_and:  return a & b;
         alu_or:   return a | b;
         alu_xor:  return a ^ b;
         alu_sll:  return a << b[4:0];
         alu_srl:  return a >> b[4:0];
         alu_sra:  return ext[xlen-1:0];
         alu_lui:  return b;
         default:  return '0;
      endcase
   endfunction

   function automatic logic branch_taken(input bru_op_t op, input xword_t a, input xword_t b);
      case (op)
         bru_beq:  return a == b;
         bru_bne:  return a != b;
         bru_blt:  return $signed(a) < $signed(b);
         bru_bge:  return $signed(a) >= $signed(b);
         bru_bltu: return a < b;
         bru_bgeu: return a >= b;
         default:  return 1'b1;
      endcase
   endfunction

   function automatic reg_idx_t rand_reg(input int lo, input int hi);
      return reg_idx_t'($urandom_range(hi, lo));
   endfunction

   task automatic check_outputs();
      n_checks++;
      assert (wen_w == p_wen[2]) else begin
         $display("%s retire at cycle %0d", p_wen[2] ? "missing" : "unexpected", cycles);
         test_errs++;
      end
      if (wen_w && p_wen[2]) begin
         assert (rd_w == p_rd[2]) else begin
            $display("[ERROR] rd_w expected %h got %h", p_rd[2], rd_w);
            test_errs++;
         end
         assert (rd_data_w == p_data[2]) else begin
            $display("[ERROR] rd_data_w expected %h got %h", p_data[2], rd_data_w);
            test_errs++;
         end
      end
      assert (branch_w == p_br[2]) else begin
         $display("%s redirect at cycle %0d", p_br[2] ? "missing" : "unexpected", cycles);
         test_errs++;
      end
      if (branch_w && p_br[2]) begin
         assert (brn_addr_w == p_addr[2]) else begin
            $display("[ERROR] brn_addr_w expected %h got %h", p_addr[2], brn_addr_w);
            test_errs++;
         end
      end
   endtask

   // one D slot that checks W, drives the slot and runs it through the model
   task automatic next_cycle(input logic v, input logic is_bru, input logic [3:0] op,
                             input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                             input xword_t imm, input logic a_pc, input logic b_imm);
      bru_op_t bop;
      logic    take;
      logic    wr;
      xword_t  res;
      xword_t  tgt;
      @(negedge clk);
      check_outputs();
      for (int i = 2; i > 0; i--) begin
         p_wen[i] = p_wen[i-1];
         p_rd[i] = p_rd[i-1];
         p_data[i] = p_data[i-1];
         p_br[i] = p_br[i-1];
         p_addr[i] = p_addr[i-1];
      end
      bop = bru_op_t'(op);
      vld_d = v;
      pc_d = pc;
      rs1_d = rs1;
      rs2_d = rs2;
      rd_d = rd;
      wen_d = v & (~is_bru | (bop inside {bru_bl, bru_jirl}));
      imm_d = is_bru ? '0 : imm;
      alu_vld_d = v & ~is_bru;
      alu_op_d = alu_op_t'(op);
      alu_a_pc_d = a_pc;
      alu_b_imm_d = b_imm;
      bru_vld_d = v & is_bru;
      bru_op_d = bop;
      bru_offset_d = is_bru ? imm : '0;
      take = 1'b0;
      wr = 1'b0;
      res = '0;
      tgt = '0;
      if (skip > 0) begin
         skip--;
      end else if (v) begin
         if (is_bru) begin
            take = branch_taken(bop, regs[rs1], regs[rs2]);
            tgt = ((bop == bru_jirl) ? regs[rs1] : pc) + imm;
            wr = bop inside {bru_bl, bru_jirl};
            res = pc + 32'd4;
         end else begin
            res = alu_model(alu_op_t'(op), a_pc ? pc : regs[rs1], b_imm ? imm : regs[rs2]);
            wr = 1'b1;
         end
         if (wr && rd != '0) begin
            regs[rd] = res;
         end
         if (wr) begin
            n_retire++;
         end
         pc = take ? tgt : pc + 32'd4;
         skip = take ? 3 : 0;
      end
      p_wen[0] = wr;
      p_rd[0] = wr ? rd : '0;
      p_data[0] = res;
      p_br[0] = take;
      p_addr[0] = tgt;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle(1'b0, 1'b0, 4'h0, '0, '0, '0, '0, 1'b0, 1'b0);
   endtask

   task automatic alu_rand();
      next_cycle(1'b1, 1'b0, 4'($urandom_range(10, 0)), rand_reg(0, 31), rand_reg(0, 31),
                 rand_reg(0, 31), $urandom, $urandom_range(7, 0) == 0,
                 1'($urandom_range(1, 0)));
   endtask

   task automatic branch_rand();
      reg_idx_t r1;
      reg_idx_t r2;
      r1 = rand_reg(0, 31);
      // equal sources often enough to take beq and bge
      r2 = ($urandom_range(3, 0) == 0) ? r1 : rand_reg(0, 31);
      next_cycle(1'b1, 1'b1, 4'($urandom_range(8, 0)), r1, r2, rand_reg(1, 31),
                 $urandom & 32'hffff_fffc, 1'b0, 1'b0);
   endtask

   task automatic end_test(input string name);
      idle(drain);
      $display("test %0d %s: %0s, %0d errors", test_no, name,
               test_errs == 0 ? "ok" : "failing", test_errs);
      total_errs += test_errs;
      test_errs = 0;
      test_no++;
   endtask

   initial begin
      void'($urandom(32'h52af));
      clk = 1'b0;
      reset = 1'b1;
      vld_d = 1'b0;
      pc_d = '0;
      rs1_d = '0;
      rs2_d = '0;
      rd_d = '0;
      wen_d = 1'b0;
      imm_d = '0;
      alu_vld_d = 1'b0;
      alu_op_d = alu_add;
      alu_a_pc_d = 1'b0;
      alu_b_imm_d = 1'b0;
      bru_vld_d = 1'b0;
      bru_op_d = bru_beq;
      bru_offset_d = '0;
      for (int i = 0; i < num_regs; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 3; i++) begin
         p_wen[i] = 1'b0;
         p_rd[i] = '0;
         p_data[i] = '0;
         p_br[i] = 1'b0;
         p_addr[i] = '0;
         hist[i] = '0;
      end
      pc = 32'h1000;
      skip = 0;
      cycles = 0;
      test_no = 1;
      n_checks = 0;
      n_retire = 0;
      test_errs = 0;
      total_errs = 0;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      idle(n_idle);
      end_test("idle after reset");

      repeat (n_alu) begin
         alu_rand();
         idle(3);
      end
      end_test("spaced alu");

      // source taken from the result d slots back with a narrow rd range
      for (int d = 1; d <= 3; d++) begin
         for (int i = 0; i < n_dep; i++) begin
            next_cycle(1'b1, 1'b0, 4'($urandom_range(10, 0)), hist[d-1],
                       hist[$urandom_range(2, 0)], rand_reg(1, 7), $urandom, 1'b0,
                       1'($urandom_range(1, 0)));
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd_d;
         end
      end
      end_test("dependent alu");

      repeat (n_r0) begin
         next_cycle(1'b1, 1'b0, 4'h0, rand_reg(1, 31), '0, '0, $urandom, 1'b0, 1'b1);
         repeat (3) begin
            next_cycle(1'b1, 1'b0, 4'($urandom_range(10, 0)), '0, '0, rand_reg(1, 31),
                       $urandom, 1'b0, 1'($urandom_range(1, 0)));
         end
      end
      end_test("register zero");

      repeat (n_br) begin
         branch_rand();
         idle(3);
      end
      end_test("branches");

      repeat (n_mix) begin
         case ($urandom_range(7, 0))
            0, 1: idle(1);
            2, 3: branch_rand();
            default: alu_rand();
         endcase
      end
      end_test("mixed stream");

      $display("total: %0d checks, %0d retires, %0d errors", n_checks, n_retire,
               total_errs);
      if (total_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
exu_geom_pkg.sv
exu_op_pkg.sv
exu_regfile.sv
exu_issue.sv
exu_execute.sv
exu_writeback.sv
exu_top.sv
tb_exu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute unit testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_exu -o tb_exu || exit 1
out=$(./obj_dir/tb_exu)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
